/* alu.sv */
`include "risc_defines.svh"

module alu (
  input  logic [`RISC_DW-1:0] a,
  input  logic [`RISC_DW-1:0] b,
  input  risc_pkg::alu_op_e   op,
  output logic [`RISC_DW-1:0] y,
  output risc_pkg::flags_t    fl
);

  localparam int MSB = `RISC_DW - 1;

  always_comb begin
    case (op)
      risc_pkg::alu_add: begin
        y    = a + b;
        // signed overflow when same-sign operands give a result of the other sign
        fl.v = (a[MSB] == b[MSB]) && (y[MSB] != a[MSB]);
      end
      risc_pkg::alu_sub: begin
        y    = a - b;
        fl.v = (a[MSB] != b[MSB]) && (y[MSB] != a[MSB]);
      end
      risc_pkg::alu_and: begin
        y    = a & b;
        fl.v = 1'b0;
      end
      default: begin
        y    = ~b;
        fl.v = 1'b0;
      end
    endcase
    fl.z = (y == '0);
    fl.n = y[MSB];
  end

endmodule

/* controller.sv */
module controller (
  input  logic               clk,
  input  logic               rst_n,
  input  risc_pkg::opcode_e  opcode,
  input  risc_pkg::alu_op_e  op,
  output risc_pkg::dp_ctrl_t ctrl,
  output risc_pkg::reg_sel_e reg_sel,
  output logic               load_ir,
  output logic               load_pc,
  output logic               clear_pc,
  output logic               halted
);

  // movr covers MOV register and MVN while alu covers ADD and AND
  typedef enum logic [3:0] {
    s_reset, s_fetch, s_load_ir, s_decode,
    s_mov_imm, s_movr1, s_movr2, s_movr3,
    s_alu1, s_alu2, s_alu3, s_alu4,
    s_cmp1, s_cmp2, s_cmp3, s_halt
  } state_e;

  state_e state;
  state_e state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) state <= s_reset;
    else state <= state_nxt;
  end

  always_comb begin
    state_nxt = s_fetch;
    case (state)
      s_fetch:   state_nxt = s_load_ir;
      s_load_ir: state_nxt = s_decode;
      s_decode: begin
        case (opcode)
          risc_pkg::opc_alu: begin
            case (op)
              risc_pkg::alu_sub:  state_nxt = s_cmp1;
              risc_pkg::alu_notb: state_nxt = s_movr1;
              default:            state_nxt = s_alu1;
            endcase
          end
          risc_pkg::opc_mov: begin
            if (op == risc_pkg::alu_and) state_nxt = s_mov_imm;
            else if (op == risc_pkg::alu_add) state_nxt = s_movr1;
          end
          risc_pkg::opc_halt: state_nxt = s_halt;
          default:            state_nxt = s_fetch;
        endcase
      end
      s_movr1: state_nxt = s_movr2;
      s_movr2: state_nxt = s_movr3;
      s_alu1:  state_nxt = s_alu2;
      s_alu2:  state_nxt = s_alu3;
      s_alu3:  state_nxt = s_alu4;
      s_cmp1:  state_nxt = s_cmp2;
      s_cmp2:  state_nxt = s_cmp3;
      s_halt:  state_nxt = s_halt;
      default: state_nxt = s_fetch;
    endcase
  end

  // alu_op and shift are filled in by the cpu from the decoder
  always_comb begin
    ctrl        = '0;
    ctrl.wb_sel = risc_pkg::wb_c;
    reg_sel     = risc_pkg::sel_rm;
    case (state)
      s_mov_imm: begin
        ctrl.w_en   = 1'b1;
        ctrl.wb_sel = risc_pkg::wb_imm;
        reg_sel     = risc_pkg::sel_rn;
      end
      s_movr1, s_alu2, s_cmp2: ctrl.en_b = 1'b1;
      s_movr2: begin
        ctrl.en_c    = 1'b1;
        ctrl.clear_a = 1'b1;
      end
      s_movr3, s_alu4: begin
        ctrl.w_en = 1'b1;
        reg_sel   = risc_pkg::sel_rd;
      end
      s_alu1, s_cmp1: begin
        ctrl.en_a = 1'b1;
        reg_sel   = risc_pkg::sel_rn;
      end
      s_alu3: ctrl.en_c = 1'b1;
      s_cmp3: ctrl.en_status = 1'b1;
      default: ;
    endcase
  end

  assign clear_pc = (state == s_reset);
  assign load_pc  = (state == s_reset) || (state == s_load_ir);
  assign load_ir  = (state == s_load_ir);
  assign halted   = (state == s_halt);

endmodule

/* cpu.sv */
`include "risc_defines.svh"

module cpu (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`RISC_AW-1:0] start_pc,
  input  logic [`RISC_DW-1:0] ram_rdata,
  output logic [`RISC_AW-1:0] ram_addr,
  output logic [`RISC_DW-1:0] out,
  output risc_pkg::flags_t    flags,
  output logic                halted
);

  risc_pkg::instr_u    ir;
  logic [`RISC_AW-1:0] pc;
  logic [`RISC_AW-1:0] next_pc;

  risc_pkg::opcode_e   opcode;
  risc_pkg::alu_op_e   dec_op;
  risc_pkg::shift_e    dec_shift;
  risc_pkg::reg_sel_e  reg_sel;
  risc_pkg::dp_ctrl_t  fsm_ctrl;
  risc_pkg::dp_ctrl_t  dp_ctrl;
  logic [`RISC_DW-1:0] sximm8;
  logic [2:0]          r_addr;
  logic [2:0]          w_addr;
  logic                load_ir;
  logic                load_pc;
  logic                clear_pc;

  controller u_controller (
    .clk      (clk),
    .rst_n    (rst_n),
    .opcode   (opcode),
    .op       (dec_op),
    .ctrl     (fsm_ctrl),
    .reg_sel  (reg_sel),
    .load_ir  (load_ir),
    .load_pc  (load_pc),
    .clear_pc (clear_pc),
    .halted   (halted)
  );

  instr_decoder u_decoder (
    .ir      (ir),
    .reg_sel (reg_sel),
    .opcode  (opcode),
    .op      (dec_op),
    .shift   (dec_shift),
    .sximm8  (sximm8),
    .r_addr  (r_addr),
    .w_addr  (w_addr)
  );

  always_comb begin
    dp_ctrl        = fsm_ctrl;
    dp_ctrl.alu_op = dec_op;
    dp_ctrl.shift  = dec_shift;
  end

  datapath u_datapath (
    .clk    (clk),
    .ctrl   (dp_ctrl),
    .r_addr (r_addr),
    .w_addr (w_addr),
    .sximm8 (sximm8),
    .out    (out),
    .flags  (flags)
  );

  assign next_pc = clear_pc ? start_pc : pc + 1'b1;

  always_ff @(posedge clk) begin
    if (load_ir) ir <= ram_rdata;
    if (load_pc) pc <= next_pc;
  end

  // the RAM serves instruction fetch only
  assign ram_addr = pc;

endmodule

/* datapath.sv */
`include "risc_defines.svh"

module datapath (
  input  logic                clk,
  input  risc_pkg::dp_ctrl_t  ctrl,
  input  logic [2:0]          r_addr,
  input  logic [2:0]          w_addr,
  input  logic [`RISC_DW-1:0] sximm8,
  output logic [`RISC_DW-1:0] out,
  output risc_pkg::flags_t    flags
);

  logic [`RISC_DW-1:0] r_data;
  logic [`RISC_DW-1:0] w_data;
  logic [`RISC_DW-1:0] a_q;
  logic [`RISC_DW-1:0] b_q;
  logic [`RISC_DW-1:0] c_q;
  logic [`RISC_DW-1:0] b_sh;
  logic [`RISC_DW-1:0] val_a;
  logic [`RISC_DW-1:0] alu_y;
  risc_pkg::flags_t    alu_fl;
  risc_pkg::flags_t    status_q;

  regfile u_regfile (
    .clk    (clk),
    .w_en   (ctrl.w_en),
    .w_addr (w_addr),
    .r_addr (r_addr),
    .w_data (w_data),
    .r_data (r_data)
  );

  // shifter on operand b
  always_comb begin
    case (ctrl.shift)
      risc_pkg::sh_lsl: b_sh = b_q << 1;
      risc_pkg::sh_lsr: b_sh = b_q >> 1;
      risc_pkg::sh_asr: b_sh = $signed(b_q) >>> 1;
      default:          b_sh = b_q;
    endcase
  end

  // moves use 0 + b
  assign val_a = ctrl.clear_a ? '0 : a_q;

  alu u_alu (
    .a  (val_a),
    .b  (b_sh),
    .op (ctrl.alu_op),
    .y  (alu_y),
    .fl (alu_fl)
  );

  assign w_data = (ctrl.wb_sel == risc_pkg::wb_imm) ? sximm8 : c_q;

  always_ff @(posedge clk) begin
    if (ctrl.en_a) a_q <= r_data;
    if (ctrl.en_b) b_q <= r_data;
    if (ctrl.en_c) c_q <= alu_y;
    if (ctrl.en_status) status_q <= alu_fl;
  end

  assign out   = c_q;
  assign flags = status_q;

endmodule

/* instr_decoder.sv */
`include "risc_defines.svh"

module instr_decoder (
  input  risc_pkg::instr_u    ir,
  input  risc_pkg::reg_sel_e  reg_sel,
  output risc_pkg::opcode_e   opcode,
  output risc_pkg::alu_op_e   op,
  output risc_pkg::shift_e    shift,
  output logic [`RISC_DW-1:0] sximm8,
  output logic [2:0]          r_addr,
  output logic [2:0]          w_addr
);

  logic [2:0] reg_addr;

  // opcode may hold a value outside the enum that the controller skips
  assign opcode = risc_pkg::opcode_e'(ir.alu.opcode);
  assign op     = risc_pkg::alu_op_e'(ir.alu.op);
  assign shift  = risc_pkg::shift_e'(ir.alu.shift);
  assign sximm8 = {{(`RISC_DW - 8){ir.mov.imm8[7]}}, ir.mov.imm8};

  always_comb begin
    case (reg_sel)
      risc_pkg::sel_rm: reg_addr = ir.alu.rm;
      risc_pkg::sel_rd: reg_addr = ir.alu.rd;
      risc_pkg::sel_rn: reg_addr = ir.alu.rn;
      default:          reg_addr = 3'd0;
    endcase
  end

  assign r_addr = reg_addr;
  assign w_addr = reg_addr;

endmodule

/* list.f */
+incdir+.
risc_pkg.sv
alu.sv
regfile.sv
datapath.sv
instr_decoder.sv
controller.sv
cpu.sv
prog_ram.sv
risc_top.sv
tb_risc_top.sv

/* prog_ram.sv */
`include "risc_defines.svh"

module prog_ram (
  input  logic                clk,
  input  logic                we,
  input  logic [`RISC_AW-1:0] waddr,
  input  logic [`RISC_AW-1:0] raddr,
  input  logic [`RISC_DW-1:0] wdata,
  output logic [`RISC_DW-1:0] rdata
);

  logic [`RISC_DW-1:0] mem [2**`RISC_AW];

  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
    rdata <= mem[raddr];
  end

endmodule

/* regfile.sv */
`include "risc_defines.svh"

module regfile (
  input  logic               clk,
  input  logic               w_en,
  input  logic [2:0]         w_addr,
  input  logic [2:0]         r_addr,
  input  logic [`RISC_DW-1:0] w_data,
  output logic [`RISC_DW-1:0] r_data
);

  logic [`RISC_DW-1:0] regs [`RISC_NREG];

  always_ff @(posedge clk) begin
    if (w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  assign r_data = regs[r_addr];

endmodule

/* risc_defines.svh */
`ifndef RISC_DEFINES_SVH
`define RISC_DEFINES_SVH

// datapath word width
`define RISC_DW 16

// program RAM address width for 256 words
`define RISC_AW 8

// general purpose registers
`define RISC_NREG 8

`endif

/* risc_pkg.sv */
package risc_pkg;

  // instruction class in ir[15:13]
  typedef enum logic [2:0] {
    opc_alu  = 3'b101,
    opc_mov  = 3'b110,
    opc_halt = 3'b111
  } opcode_e;

  // in the move class, alu_and (10) means immediate and alu_add (00) means register
  typedef enum logic [1:0] {
    alu_add  = 2'b00,
    alu_sub  = 2'b01,
    alu_and  = 2'b10,
    alu_notb = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none = 2'b00,
    sh_lsl  = 2'b01,
    sh_lsr  = 2'b10,
    sh_asr  = 2'b11
  } shift_e;

  typedef struct packed {
    logic [2:0] opcode;
    logic [1:0] op;
    logic [2:0] rn;
    logic [2:0] rd;
    logic [1:0] shift;
    logic [2:0] rm;
  } alu_fmt_t;

  typedef struct packed {
    logic [2:0] opcode;
    logic [1:0] op;
    logic [2:0] rn;
    logic [7:0] imm8;
  } mov_fmt_t;

  // one 16-bit word read in two ways
  typedef union packed {
    alu_fmt_t alu;
    mov_fmt_t mov;
  } instr_u;

  // 2'b11 is unused
  typedef enum logic [1:0] {
    sel_rm = 2'b00,
    sel_rd = 2'b01,
    sel_rn = 2'b10
  } reg_sel_e;

  typedef enum logic [1:0] {
    wb_c   = 2'b00,
    wb_imm = 2'b10
  } wb_sel_e;

  typedef struct packed {
    logic     w_en;
    logic     en_a;
    logic     en_b;
    logic     en_c;
    logic     en_status;
    logic     clear_a;
    wb_sel_e  wb_sel;
    alu_op_e  alu_op;
    shift_e   shift;
  } dp_ctrl_t;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

endpackage

/* risc_top.sv */
`include "risc_defines.svh"

module risc_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`RISC_AW-1:0] start_pc,
  input  logic                load_we,
  input  logic [`RISC_AW-1:0] load_addr,
  input  logic [`RISC_DW-1:0] load_data,
  output logic [`RISC_DW-1:0] out,
  output risc_pkg::flags_t    flags,
  output logic                halted
);

  logic [`RISC_AW-1:0] ram_addr;
  logic [`RISC_DW-1:0] ram_rdata;
  logic                ram_we;

  // program load only while the cpu is held in reset
  assign ram_we = load_we && !rst_n;

  cpu u_cpu (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_pc  (start_pc),
    .ram_rdata (ram_rdata),
    .ram_addr  (ram_addr),
    .out       (out),
    .flags     (flags),
    .halted    (halted)
  );

  prog_ram u_ram (
    .clk   (clk),
    .we    (ram_we),
    .waddr (load_addr),
    .raddr (ram_addr),
    .wdata (load_data),
    .rdata (ram_rdata)
  );

endmodule

/* tb_risc_top.sv */
`include "risc_defines.svh"

module tb_risc_top;

  logic                clk;
  logic                rst_n;
  logic [`RISC_AW-1:0] start_pc;
  logic                load_we;
  logic [`RISC_AW-1:0] load_addr;
  logic [`RISC_DW-1:0] load_data;
  logic [`RISC_DW-1:0] out;
  risc_pkg::flags_t    flags;
  logic                halted;

  logic [`RISC_DW-1:0] image [2**`RISC_AW];
  logic [`RISC_AW-1:0] wptr;
  logic [`RISC_AW-1:0] prog_pc;
  logic [`RISC_DW-1:0] exp_c;
  risc_pkg::flags_t    exp_fl;
  string               test_name;
  int                  req_id;
  int                  ack_id;
  int                  test_errs;
  int                  pass_count;
  int                  fail_count;
  int unsigned         seed;
  int unsigned         rnd;
  int                  len;

  risc_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_pc  (start_pc),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .out       (out),
    .flags     (flags),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] movi_word(input logic [2:0] rn, input logic [7:0] imm);
    return {3'b110, 2'b10, rn, imm};
  endfunction

  function automatic logic [15:0] reg_word(input logic [4:0] cls, input logic [2:0] rn,
                                           input logic [2:0] rd, input logic [1:0] sh,
                                           input logic [2:0] rm);
    return {cls, rn, rd, sh, rm};
  endfunction

  // kind 0..5 is movi, movr, add, cmp, and, mvn
  function automatic logic [15:0] rand_instr(input int kind);
    int unsigned r;
    logic [15:0] w;
    r = $urandom;
    w = r[15:0];
    case (kind)
      0: w[15:11] = 5'b11010;
      1: w[15:11] = 5'b11000;
      2: w[15:11] = 5'b10100;
      3: w[15:11] = 5'b10101;
      4: w[15:11] = 5'b10110;
      default: w[15:11] = 5'b10111;
    endcase
    return w;
  endfunction

  function automatic logic [15:0] shift_val(input logic [15:0] v, input logic [1:0] sh);
    case (sh)
      2'd1: return {v[14:0], 1'b0};
      2'd2: return {1'b0, v[15:1]};
      2'd3: return {v[15], v[15:1]};
      default: return v;
    endcase
  endfunction

  // instruction-set model returning {c, z, n, v}
  function automatic logic [18:0] ref_run(input logic [7:0] pc0);
    logic [15:0] r [8];
    logic [15:0] c;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] d;
    logic [15:0] ins;
    logic [2:0]  fl;
    logic [7:0]  pc;
    int          steps;
    int          diff;
    c = 'x;
    fl = 'x;
    pc = pc0;
    steps = 0;
    ins = 16'h0;
    while (ins[15:13] != 3'b111 && steps < 1024) begin
      ins = image[pc];
      pc = pc + 8'd1;
      steps++;
      a = r[ins[10:8]];
      b = shift_val(r[ins[2:0]], ins[4:3]);
      if (ins[15:11] == 5'b11010) begin
        r[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
      end else if (ins[15:11] == 5'b11000) begin
        c = b;
        r[ins[7:5]] = c;
      end else if (ins[15:13] == 3'b101) begin
        // full-range signed difference
        diff = $signed(a) - $signed(b);
        d = diff[15:0];
        case (ins[12:11])
          2'b00: c = a + b;
          2'b10: c = a & b;
          2'b11: c = ~b;
          default: fl = {d == 16'd0, d[15], (diff < -32768) || (diff > 32767)};
        endcase
        if (ins[12:11] != 2'b01) r[ins[7:5]] = c;
      end
    end
    return {c, fl};
  endfunction

  task automatic new_image(input logic [7:0] pc0);
    for (int i = 0; i < 256; i++) begin
      // halt word tagged with its own address
      image[i] = {3'b111, 5'd0, i[7:0]};
    end
    prog_pc = pc0;
    wptr = pc0;
  endtask

  task automatic put(input logic [15:0] w);
    image[wptr] = w;
    wptr = wptr + 8'd1;
  endtask

  // every register, C and status get defined values
  task automatic add_prelude();
    int unsigned r;
    for (int k = 0; k < 8; k++) begin
      r = $urandom;
      put(movi_word(k[2:0], r[7:0]));
    end
    put(reg_word(5'b10101, 3'd0, 3'd0, 2'd0, 3'd1));
    put(reg_word(5'b11000, 3'd0, 3'd0, 2'd0, 3'd0));
  endtask

  task automatic finish_run();
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic run_program(input string name);
    int cycles;
    put(16'he000);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    start_pc = prog_pc;
    for (int i = 0; i < 256; i++) begin
      load_we = 1'b1;
      load_addr = i[7:0];
      load_data = image[i];
      @(posedge clk);
      #1;
    end
    load_we = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: the processor never halted within 2000 cycles", name);
      fail_count++;
      finish_run();
    end else begin
      test_name = name;
      {exp_c, exp_fl} = ref_run(prog_pc);
      req_id++;
      cycles = 0;
      while (ack_id != req_id && cycles < 10) begin
        @(negedge clk);
        cycles++;
      end
      if (ack_id != req_id) begin
        $display("%s: the result was never compared", name);
        fail_count++;
        finish_run();
      end
    end
  endtask

  always @(negedge clk) begin
    if (req_id != ack_id) begin
      test_errs = 0;
      assert (out === exp_c) else begin
        $display("** Error %s: out expected %h actual %h", test_name, exp_c, out);
        test_errs++;
      end
      assert (flags === exp_fl) else begin
        $display("** Error %s: flags expected %b actual %b", test_name, exp_fl, flags);
        test_errs++;
      end
      if (test_errs == 0) begin
        pass_count++;
        $display("%s passed", test_name);
      end else begin
        fail_count++;
        $display("%s failed with %0d errors", test_name, test_errs);
      end
      ack_id = req_id;
    end
  end

  initial begin
    seed = $urandom(97430);
    rst_n = 1'b0;
    start_pc = '0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    req_id = 0;
    ack_id = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (8) @(posedge clk);

    new_image(8'h00);
    add_prelude();
    put(movi_word(3'd1, 8'h85));
    // chained so each shift reaches out
    put(reg_word(5'b11000, 3'd0, 3'd3, 2'd0, 3'd1));
    put(reg_word(5'b11000, 3'd0, 3'd4, 2'd1, 3'd3));
    put(reg_word(5'b11000, 3'd0, 3'd5, 2'd3, 3'd4));
    put(reg_word(5'b11000, 3'd0, 3'd6, 2'd2, 3'd5));
    run_program("mov_shift");

    // 0x7f00 and 0x8000 built by shifting left
    new_image(8'h10);
    add_prelude();
    put(movi_word(3'd1, 8'h7f));
    put(movi_word(3'd3, 8'h80));
    for (int k = 0; k < 8; k++) begin
      put(reg_word(5'b11000, 3'd0, 3'd1, 2'd1, 3'd1));
      put(reg_word(5'b11000, 3'd0, 3'd3, 2'd1, 3'd3));
    end
    put(reg_word(5'b10100, 3'd1, 3'd2, 2'd0, 3'd1));
    put(reg_word(5'b10100, 3'd3, 3'd4, 2'd0, 3'd3));
    put(reg_word(5'b10101, 3'd1, 3'd0, 2'd0, 3'd3));
    run_program("add_cmp_overflow");

    new_image(8'h20);
    add_prelude();
    for (int k = 0; k < 12; k++) put(rand_instr(4 + $urandom % 2));
    run_program("and_mvn_chain");

    new_image(8'hc5);
    add_prelude();
    for (int k = 0; k < 6; k++) begin
      put(rand_instr($urandom % 6));
      rnd = $urandom;
      put({3'(rnd[20:16] % 5), rnd[12:0]});
    end
    put(reg_word(5'b11001, 3'd2, 3'd3, 2'd0, 3'd4));
    put(reg_word(5'b11011, 3'd2, 3'd3, 2'd0, 3'd4));
    run_program("skip_unknown");
    for (int k = 0; k < 20; k++) begin
      @(negedge clk);
      assert (halted) else begin
        $display("skip_unknown: halted dropped after the HALT instruction");
        fail_count++;
      end
    end

    for (int t = 0; t < 20; t++) begin
      rnd = $urandom;
      new_image(rnd[7:0]);
      add_prelude();
      len = 5 + $urandom % 26;
      for (int k = 0; k < len; k++) put(rand_instr($urandom % 6));
      run_program($sformatf("random_%0d", t));
    end

    finish_run();
  end

endmodule
